// File: idu_top.f
+incdir+verif
source/idu_pkg.sv
source/ctrl_decode.sv
source/imm_gen.sv
source/gpr_file.sv
source/idu_top.sv
verif/idu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module idu_tb -f idu_top.f -o idu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/idu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: source/ctrl_decode.sv
// Instruction control decoder
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode (
  input  wire                             i_clk,
  input  wire                             i_rst_n,
  input  wire                             i_inst_valid,
  input  wire [idu_pkg::INST_W-1:0]       i_inst,
  output logic                            o_dec_valid,
  output logic [idu_pkg::REG_ADDR_W-1:0]  o_rd,
  output idu_pkg::alu_op_e                o_alu_op,
  output logic                            o_alu_a_pc,
  output idu_pkg::alu_b_src_e             o_alu_b_src,
  output logic                            o_word_cut,
  output logic                            o_reg_wr,
  output logic                            o_mem_re,
  output logic                            o_mem_wr,
  output logic                            o_mem_to_reg,
  output idu_pkg::mem_op_e                o_mem_op,
  output logic                            o_bren,
  output idu_pkg::br_func_e               o_br_func,
  output logic                            o_invalid,
  output idu_pkg::imm_fmt_e               o_imm_fmt
);

  logic [6:0] opcode, funct7;
  logic [2:0] funct3;
  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  logic f7_base, f7_alt, sh_base, sh_alt;
  assign f7_base = (funct7 == idu_pkg::F7_BASE);
  assign f7_alt  = (funct7 == idu_pkg::F7_ALT);
  assign sh_base = (funct7[6:1] == idu_pkg::F7_BASE[6:1]); // rv64 shamt is 6 bits
  assign sh_alt  = (funct7[6:1] == idu_pkg::F7_ALT[6:1]);

  logic op_br, op_ld, op_st, op_imm, op_immw, op_reg, op_regw;
  assign op_br   = (opcode == idu_pkg::OP_BRANCH);
  assign op_ld   = (opcode == idu_pkg::OP_LOAD);
  assign op_st   = (opcode == idu_pkg::OP_STORE);
  assign op_imm  = (opcode == idu_pkg::OP_IMM);
  assign op_immw = (opcode == idu_pkg::OP_IMM_W);
  assign op_reg  = (opcode == idu_pkg::OP_REG);
  assign op_regw = (opcode == idu_pkg::OP_REG_W);

  logic inst_lui, inst_auipc, inst_jal, inst_jalr;
  assign inst_lui   = (opcode == idu_pkg::OP_LUI);
  assign inst_auipc = (opcode == idu_pkg::OP_AUIPC);
  assign inst_jal   = (opcode == idu_pkg::OP_JAL);
  assign inst_jalr  = (opcode == idu_pkg::OP_JALR) & (funct3 == 3'b000);

  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  assign inst_beq  = op_br & (funct3 == 3'b000);
  assign inst_bne  = op_br & (funct3 == 3'b001);
  assign inst_blt  = op_br & (funct3 == 3'b100);
  assign inst_bge  = op_br & (funct3 == 3'b101);
  assign inst_bltu = op_br & (funct3 == 3'b110);
  assign inst_bgeu = op_br & (funct3 == 3'b111);

  logic inst_load, inst_store;
  assign inst_load  = op_ld & (funct3 != 3'b111); // lb lh lw ld lbu lhu lwu
  assign inst_store = op_st & ~funct3[2];         // sb sh sw sd

  logic inst_addi, inst_slti, inst_sltiu, inst_xori, inst_ori, inst_andi;
  logic inst_slli, inst_srli, inst_srai;
  assign inst_addi  = op_imm & (funct3 == 3'b000);
  assign inst_slti  = op_imm & (funct3 == 3'b010);
  assign inst_sltiu = op_imm & (funct3 == 3'b011);
  assign inst_xori  = op_imm & (funct3 == 3'b100);
  assign inst_ori   = op_imm & (funct3 == 3'b110);
  assign inst_andi  = op_imm & (funct3 == 3'b111);
  assign inst_slli  = op_imm & (funct3 == 3'b001) & sh_base;
  assign inst_srli  = op_imm & (funct3 == 3'b101) & sh_base;
  assign inst_srai  = op_imm & (funct3 == 3'b101) & sh_alt;

  logic inst_addiw, inst_slliw, inst_srliw, inst_sraiw;
  assign inst_addiw = op_immw & (funct3 == 3'b000);
  assign inst_slliw = op_immw & (funct3 == 3'b001) & f7_base;
  assign inst_srliw = op_immw & (funct3 == 3'b101) & f7_base;
  assign inst_sraiw = op_immw & (funct3 == 3'b101) & f7_alt;

  logic inst_add, inst_sub, inst_sll, inst_slt, inst_sltu;
  logic inst_xor, inst_srl, inst_sra, inst_or, inst_and;
  assign inst_add  = op_reg & (funct3 == 3'b000) & f7_base;
  assign inst_sub  = op_reg & (funct3 == 3'b000) & f7_alt;
  assign inst_sll  = op_reg & (funct3 == 3'b001) & f7_base;
  assign inst_slt  = op_reg & (funct3 == 3'b010) & f7_base;
  assign inst_sltu = op_reg & (funct3 == 3'b011) & f7_base;
  assign inst_xor  = op_reg & (funct3 == 3'b100) & f7_base;
  assign inst_srl  = op_reg & (funct3 == 3'b101) & f7_base;
  assign inst_sra  = op_reg & (funct3 == 3'b101) & f7_alt;
  assign inst_or   = op_reg & (funct3 == 3'b110) & f7_base;
  assign inst_and  = op_reg & (funct3 == 3'b111) & f7_base;

  logic inst_addw, inst_subw, inst_sllw, inst_srlw, inst_sraw;
  assign inst_addw = op_regw & (funct3 == 3'b000) & f7_base;
  assign inst_subw = op_regw & (funct3 == 3'b000) & f7_alt;
  assign inst_sllw = op_regw & (funct3 == 3'b001) & f7_base;
  assign inst_srlw = op_regw & (funct3 == 3'b101) & f7_base;
  assign inst_sraw = op_regw & (funct3 == 3'b101) & f7_alt;

  logic cls_r, cls_i, cls_u, cls_s, cls_b, cls_j;
  assign cls_r = |{inst_add, inst_sub, inst_sll, inst_slt, inst_sltu, inst_xor, inst_srl,
                   inst_sra, inst_or, inst_and, inst_addw, inst_subw, inst_sllw, inst_srlw,
                   inst_sraw};
  assign cls_i = |{inst_jalr, inst_load, inst_addi, inst_slti, inst_sltiu, inst_xori,
                   inst_ori, inst_andi, inst_slli, inst_srli, inst_srai, inst_addiw,
                   inst_slliw, inst_srliw, inst_sraiw};
  assign cls_u = inst_lui | inst_auipc;
  assign cls_s = inst_store;
  assign cls_b = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};
  assign cls_j = inst_jal;

  logic word_cut;
  assign word_cut = |{inst_addiw, inst_slliw, inst_srliw, inst_sraiw, inst_addw, inst_subw,
                      inst_sllw, inst_srlw, inst_sraw};

  idu_pkg::alu_op_e  alu_op;
  idu_pkg::mem_op_e  mem_op;
  idu_pkg::br_func_e br_func;

  always_comb begin
    if (inst_lui) alu_op = idu_pkg::ALU_COPY_IMM;
    else if (|{inst_auipc, inst_addi, inst_add, inst_jal, inst_jalr, inst_load, inst_store,
               inst_addiw, inst_addw}) alu_op = idu_pkg::ALU_ADD;
    else if (inst_sub | inst_subw) alu_op = idu_pkg::ALU_SUB;
    else if (inst_slt | inst_slti) alu_op = idu_pkg::ALU_SLT;
    else if (inst_sltu | inst_sltiu) alu_op = idu_pkg::ALU_SLTU;
    else if (inst_xor | inst_xori) alu_op = idu_pkg::ALU_XOR;
    else if (inst_and | inst_andi) alu_op = idu_pkg::ALU_AND;
    else if (inst_or | inst_ori) alu_op = idu_pkg::ALU_OR;
    else if (|{inst_sll, inst_slli, inst_slliw, inst_sllw}) alu_op = idu_pkg::ALU_SLL;
    else if (|{inst_srl, inst_srli, inst_srliw, inst_srlw}) alu_op = idu_pkg::ALU_SRL;
    else if (|{inst_sra, inst_srai, inst_sraiw, inst_sraw}) alu_op = idu_pkg::ALU_SRA;
    else alu_op = idu_pkg::ALU_INVALID; // branches land here too
  end

  always_comb begin
    mem_op = idu_pkg::MEM_NONE;
    if (inst_load | inst_store) begin
      case (funct3)
        3'b000:  mem_op = idu_pkg::MEM_LB;
        3'b001:  mem_op = idu_pkg::MEM_LH;
        3'b010:  mem_op = idu_pkg::MEM_LW;
        3'b011:  mem_op = idu_pkg::MEM_LD;
        3'b100:  mem_op = idu_pkg::MEM_LBU;
        3'b101:  mem_op = idu_pkg::MEM_LHU;
        3'b110:  mem_op = idu_pkg::MEM_LWU;
        default: mem_op = idu_pkg::MEM_NONE;
      endcase
    end
  end

  always_comb begin
    if (inst_jalr) br_func = idu_pkg::BR_JALR;
    else if (inst_beq) br_func = idu_pkg::BR_BEQ;
    else if (inst_bne) br_func = idu_pkg::BR_BNE;
    else if (inst_blt) br_func = idu_pkg::BR_BLT;
    else if (inst_bge) br_func = idu_pkg::BR_BGE;
    else if (inst_bltu) br_func = idu_pkg::BR_BLTU;
    else if (inst_bgeu) br_func = idu_pkg::BR_BGEU;
    else br_func = idu_pkg::BR_JAL;
  end

  always_comb begin
    if (cls_i) o_imm_fmt = idu_pkg::IMM_I;
    else if (cls_u) o_imm_fmt = idu_pkg::IMM_U;
    else if (cls_s) o_imm_fmt = idu_pkg::IMM_S;
    else if (cls_b) o_imm_fmt = idu_pkg::IMM_B;
    else if (cls_j) o_imm_fmt = idu_pkg::IMM_J;
    else o_imm_fmt = idu_pkg::IMM_NONE;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || !i_inst_valid) begin // idle cycle looks like a bubble
      o_dec_valid  <= 1'b0;
      o_rd         <= '0;
      o_alu_op     <= idu_pkg::ALU_ADD;
      o_alu_a_pc   <= 1'b0;
      o_alu_b_src  <= idu_pkg::SRC_RS2;
      o_word_cut   <= 1'b0;
      o_reg_wr     <= 1'b0;
      o_mem_re     <= 1'b0;
      o_mem_wr     <= 1'b0;
      o_mem_to_reg <= 1'b0;
      o_mem_op     <= idu_pkg::MEM_NONE;
      o_bren       <= 1'b0;
      o_br_func    <= idu_pkg::BR_JAL;
      o_invalid    <= 1'b0;
    end else begin
      o_dec_valid  <= 1'b1;
      o_rd         <= i_inst[11:7];
      o_alu_op     <= alu_op;
      o_alu_a_pc   <= inst_jal | inst_auipc | inst_jalr;
      if (inst_jal | inst_jalr) o_alu_b_src <= idu_pkg::SRC_FOUR;
      else if (cls_i | cls_u | cls_s) o_alu_b_src <= idu_pkg::SRC_IMM;
      else o_alu_b_src <= idu_pkg::SRC_RS2;
      o_word_cut   <= word_cut;
      o_reg_wr     <= cls_r | cls_i | cls_u | cls_j;
      o_mem_re     <= inst_load;
      o_mem_wr     <= inst_store;
      o_mem_to_reg <= inst_load;
      o_mem_op     <= mem_op;
      o_bren       <= cls_b | inst_jal | inst_jalr;
      o_br_func    <= br_func;
      o_invalid    <= ~|{cls_r, cls_i, cls_u, cls_s, cls_b, cls_j} & (|i_inst);
    end
  end

  a_one_class: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0({cls_r, cls_i, cls_u, cls_s, cls_b, cls_j}));

  a_mem_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_mem_re && o_mem_wr));

endmodule

`default_nettype wire

// File: source/gpr_file.sv
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
  input  wire                               i_clk,
  input  wire                               i_rst_n,
  input  wire [idu_pkg::REG_ADDR_W-1:0]     i_rs1,
  input  wire [idu_pkg::REG_ADDR_W-1:0]     i_rs2,
  input  wire                               i_wb_wen,
  input  wire [idu_pkg::REG_ADDR_W-1:0]     i_wb_waddr,
  input  wire [idu_pkg::XLEN-1:0]           i_wb_wdata,
  output logic [idu_pkg::XLEN-1:0]          o_rs1_data,
  output logic [idu_pkg::XLEN-1:0]          o_rs2_data
);

  logic [idu_pkg::XLEN-1:0] regs [idu_pkg::NUM_REGS];

  // write-back port, x0 stays unwritten
  always_ff @(posedge i_clk) begin
    if (i_wb_wen && (i_wb_waddr != '0)) begin
      regs[i_wb_waddr] <= i_wb_wdata;
    end
  end

  // registered read sees contents before this edge's write
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_rs1_data <= '0;
      o_rs2_data <= '0;
    end else begin
      o_rs1_data <= (i_rs1 == '0) ? '0 : regs[i_rs1];
      o_rs2_data <= (i_rs2 == '0) ? '0 : regs[i_rs2];
    end
  end

endmodule

`default_nettype wire

// File: source/idu_pkg.sv
// RV64I decode definitions
`default_nettype none

package idu_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM_W  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG_W  = 7'b0111011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub / sra

  typedef enum logic [4:0] {
    ALU_ADD      = 5'b00000,
    ALU_SUB      = 5'b00001,
    ALU_SLT      = 5'b00010,
    ALU_SLTU     = 5'b00011,
    ALU_XOR      = 5'b00100,
    ALU_AND      = 5'b00101,
    ALU_OR       = 5'b00110,
    ALU_SLL      = 5'b00111,
    ALU_SRL      = 5'b01000,
    ALU_SRA      = 5'b01001,
    ALU_COPY_IMM = 5'b01111, // lui
    ALU_INVALID  = 5'b11111
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_RS2  = 2'b00,
    SRC_IMM  = 2'b01,
    SRC_FOUR = 2'b10 // link address pc + 4
  } alu_b_src_e;

  typedef enum logic [2:0] {
    MEM_LB   = 3'd0,
    MEM_LBU  = 3'd1,
    MEM_LH   = 3'd2,
    MEM_LHU  = 3'd3,
    MEM_LW   = 3'd4,
    MEM_LWU  = 3'd5,
    MEM_LD   = 3'd6,
    MEM_NONE = 3'd7
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_JAL  = 3'd0,
    BR_JALR = 3'd1,
    BR_BEQ  = 3'd2,
    BR_BNE  = 3'd3,
    BR_BLT  = 3'd4,
    BR_BGE  = 3'd5,
    BR_BLTU = 3'd6,
    BR_BGEU = 3'd7
  } br_func_e;

  typedef enum logic [2:0] {
    IMM_I    = 3'd0,
    IMM_U    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_J    = 3'd4,
    IMM_NONE = 3'd7 // R-type, no immediate
  } imm_fmt_e;

endpackage

`default_nettype wire

// File: source/idu_top.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module idu_top (
  input  wire                               i_clk,
  input  wire                               i_rst_n,
  input  wire                               i_inst_valid,
  input  wire [idu_pkg::INST_W-1:0]         i_inst,
  input  wire                               i_wb_wen,
  input  wire [idu_pkg::REG_ADDR_W-1:0]     i_wb_waddr,
  input  wire [idu_pkg::XLEN-1:0]           i_wb_wdata,
  output logic                              o_dec_valid,
  output logic [idu_pkg::REG_ADDR_W-1:0]    o_rd,
  output idu_pkg::alu_op_e                  o_alu_op,
  output logic                              o_alu_a_pc,
  output idu_pkg::alu_b_src_e               o_alu_b_src,
  output logic                              o_word_cut,
  output logic                              o_reg_wr,
  output logic                              o_mem_re,
  output logic                              o_mem_wr,
  output logic                              o_mem_to_reg,
  output idu_pkg::mem_op_e                  o_mem_op,
  output logic                              o_bren,
  output idu_pkg::br_func_e                 o_br_func,
  output logic                              o_invalid,
  output logic [idu_pkg::XLEN-1:0]          o_imm,
  output logic [idu_pkg::XLEN-1:0]          o_rs1_data,
  output logic [idu_pkg::XLEN-1:0]          o_rs2_data
);

  logic [idu_pkg::REG_ADDR_W-1:0] rs1, rs2;
  idu_pkg::imm_fmt_e              imm_fmt;

  assign rs1 = i_inst[19:15];
  assign rs2 = i_inst[24:20];

  ctrl_decode ctrl_decode_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_dec_valid  (o_dec_valid),
    .o_rd         (o_rd),
    .o_alu_op     (o_alu_op),
    .o_alu_a_pc   (o_alu_a_pc),
    .o_alu_b_src  (o_alu_b_src),
    .o_word_cut   (o_word_cut),
    .o_reg_wr     (o_reg_wr),
    .o_mem_re     (o_mem_re),
    .o_mem_wr     (o_mem_wr),
    .o_mem_to_reg (o_mem_to_reg),
    .o_mem_op     (o_mem_op),
    .o_bren       (o_bren),
    .o_br_func    (o_br_func),
    .o_invalid    (o_invalid),
    .o_imm_fmt    (imm_fmt)
  );

  imm_gen imm_gen_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_imm_fmt    (imm_fmt),
    .o_imm        (o_imm)
  );

  gpr_file gpr_file_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_wb_wen     (i_wb_wen),
    .i_wb_waddr   (i_wb_waddr),
    .i_wb_wdata   (i_wb_wdata),
    .o_rs1_data   (o_rs1_data),
    .o_rs2_data   (o_rs2_data)
  );

endmodule

`default_nettype wire

// File: source/imm_gen.sv
// Immediate generator
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  wire                         i_clk,
  input  wire                         i_rst_n,
  input  wire                         i_inst_valid,
  input  wire [idu_pkg::INST_W-1:0]   i_inst,
  input  idu_pkg::imm_fmt_e           i_imm_fmt,
  output logic [idu_pkg::XLEN-1:0]    o_imm
);

  localparam int XL = idu_pkg::XLEN;

  logic [XL-1:0] imm_i, imm_u, imm_s, imm_b, imm_j;
  logic [XL-1:0] imm_sel;

  assign imm_i = {{(XL-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(XL-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(XL-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XL-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{(XL-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_imm_fmt)
      idu_pkg::IMM_I: imm_sel = imm_i;
      idu_pkg::IMM_U: imm_sel = imm_u;
      idu_pkg::IMM_S: imm_sel = imm_s;
      idu_pkg::IMM_B: imm_sel = imm_b;
      idu_pkg::IMM_J: imm_sel = imm_j;
      default:        imm_sel = '0; // R-type and unknown
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_imm <= '0;
    end else if (i_inst_valid) begin
      o_imm <= imm_sel; // held across idle cycles
    end
  end

  // branch and jump targets are halfword aligned
  a_bj_align: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_inst_valid && (i_imm_fmt inside {idu_pkg::IMM_B, idu_pkg::IMM_J}) |=> !o_imm[0]);

endmodule

`default_nettype wire

// File: verif/idu_tb_checks.svh
// Decode stage checks

  function automatic logic is_legal(input logic [31:0] inst);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    op = inst[6:0];
    f3 = inst[14:12];
    f7 = inst[31:25];
    case (op)
      idu_pkg::OP_LUI, idu_pkg::OP_AUIPC, idu_pkg::OP_JAL: return 1'b1;
      idu_pkg::OP_JALR:   return f3 == 3'b000;
      idu_pkg::OP_BRANCH: return f3[2:1] != 2'b01;
      idu_pkg::OP_LOAD:   return f3 != 3'b111;
      idu_pkg::OP_STORE:  return !f3[2];
      idu_pkg::OP_IMM:
        if (f3 == 3'b001) return f7[6:1] == 6'd0; // 6-bit shamt
        else if (f3 == 3'b101) return (f7[6:1] == 6'd0) || (f7[6:1] == 6'b010000);
        else return 1'b1;
      idu_pkg::OP_IMM_W:
        if (f3 == 3'b000) return 1'b1;
        else if (f3 == 3'b001) return f7 == 7'd0;
        else if (f3 == 3'b101) return (f7 == 7'd0) || (f7 == 7'h20);
        else return 1'b0;
      idu_pkg::OP_REG:
        return (f7 == 7'd0) || ((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101));
      idu_pkg::OP_REG_W:
        if (f3 == 3'b000 || f3 == 3'b101) return (f7 == 7'd0) || (f7 == 7'h20);
        else if (f3 == 3'b001) return f7 == 7'd0;
        else return 1'b0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic legal_with_opcode(input logic [31:0] inst, input logic [6:0] op);
    return is_legal(inst) && (inst[6:0] == op);
  endfunction

  function automatic logic is_arith(input logic [31:0] inst);
    return legal_with_opcode(inst, idu_pkg::OP_IMM) || legal_with_opcode(inst, idu_pkg::OP_IMM_W)
        || legal_with_opcode(inst, idu_pkg::OP_REG) || legal_with_opcode(inst, idu_pkg::OP_REG_W);
  endfunction

  function automatic logic is_jump(input logic [31:0] inst);
    return legal_with_opcode(inst, idu_pkg::OP_JAL) || legal_with_opcode(inst, idu_pkg::OP_JALR);
  endfunction

  function automatic logic [63:0] exp_imm(input logic [31:0] inst);
    if (!is_legal(inst)) return 64'd0;
    case (inst[6:0])
      idu_pkg::OP_IMM, idu_pkg::OP_IMM_W, idu_pkg::OP_LOAD, idu_pkg::OP_JALR:
        return {{52{inst[31]}}, inst[31:20]};
      idu_pkg::OP_STORE:  return {{52{inst[31]}}, inst[31:25], inst[11:7]};
      idu_pkg::OP_BRANCH:
        return {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      idu_pkg::OP_LUI, idu_pkg::OP_AUIPC: return {{32{inst[31]}}, inst[31:12], 12'h000};
      idu_pkg::OP_JAL:
        return {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: return 64'd0; // register forms carry none
    endcase
  endfunction

  function automatic idu_pkg::alu_op_e exp_alu_op(input logic [31:0] inst);
    logic alt;
    alt = inst[30] && (inst[5] || inst[14:12] == 3'b101); // sub exists only in reg forms
    case (inst[14:12])
      3'b000:  return alt ? idu_pkg::ALU_SUB : idu_pkg::ALU_ADD;
      3'b001:  return idu_pkg::ALU_SLL;
      3'b010:  return idu_pkg::ALU_SLT;
      3'b011:  return idu_pkg::ALU_SLTU;
      3'b100:  return idu_pkg::ALU_XOR;
      3'b101:  return alt ? idu_pkg::ALU_SRA : idu_pkg::ALU_SRL;
      3'b110:  return idu_pkg::ALU_OR;
      default: return idu_pkg::ALU_AND;
    endcase
  endfunction

  function automatic idu_pkg::mem_op_e exp_mem_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return idu_pkg::MEM_LB;
      3'b001:  return idu_pkg::MEM_LH;
      3'b010:  return idu_pkg::MEM_LW;
      3'b011:  return idu_pkg::MEM_LD;
      3'b100:  return idu_pkg::MEM_LBU;
      3'b101:  return idu_pkg::MEM_LHU;
      3'b110:  return idu_pkg::MEM_LWU;
      default: return idu_pkg::MEM_NONE;
    endcase
  endfunction

  function automatic idu_pkg::br_func_e exp_br_func(input logic [31:0] inst);
    if (inst[6:0] == idu_pkg::OP_JAL) return idu_pkg::BR_JAL;
    if (inst[6:0] == idu_pkg::OP_JALR) return idu_pkg::BR_JALR;
    case (inst[14:12])
      3'b000:  return idu_pkg::BR_BEQ;
      3'b001:  return idu_pkg::BR_BNE;
      3'b100:  return idu_pkg::BR_BLT;
      3'b101:  return idu_pkg::BR_BGE;
      3'b110:  return idu_pkg::BR_BLTU;
      default: return idu_pkg::BR_BGEU;
    endcase
  endfunction

  function automatic logic exp_reg_wr(input logic [31:0] inst);
    return is_legal(inst) && (inst[6:0] != idu_pkg::OP_STORE)
        && (inst[6:0] != idu_pkg::OP_BRANCH);
  endfunction

  // sampled mid cycle, outputs belong to the previous edge's inputs
  a_idle: assert property (@(negedge i_clk) prev_idle |->
    !o_dec_valid && !o_reg_wr && !o_mem_re && !o_mem_wr && !o_bren
    && o_mem_op == idu_pkg::MEM_NONE && o_alu_op == idu_pkg::ALU_ADD)
    else log_mismatch("control outputs active after an idle cycle");

  a_reset: assert property (@(negedge i_clk) prev_rst |->
    o_imm == 64'd0 && !o_invalid && !o_mem_to_reg)
    else log_mismatch("outputs not cleared by reset");

  a_valid: assert property (@(negedge i_clk) prev_valid |->
    o_dec_valid && o_rd == prev_inst[11:7])
    else log_mismatch($sformatf("valid/rd wrong for inst %h", prev_inst));

  a_imm: assert property (@(negedge i_clk) prev_valid |-> o_imm == exp_imm(prev_inst))
    else log_mismatch($sformatf("imm got %h exp %h for inst %h",
                                o_imm, exp_imm(prev_inst), prev_inst));

  a_alu: assert property (@(negedge i_clk) prev_valid && is_arith(prev_inst) |->
    o_alu_op == exp_alu_op(prev_inst) && !o_alu_a_pc
    && o_alu_b_src == (prev_inst[5] ? idu_pkg::SRC_RS2 : idu_pkg::SRC_IMM)
    && o_word_cut == prev_inst[3]) // W opcodes have bit 3 set
    else log_mismatch($sformatf("alu control wrong for inst %h", prev_inst));

  a_jump_src: assert property (@(negedge i_clk) prev_valid && is_jump(prev_inst) |->
    o_alu_a_pc && o_alu_b_src == idu_pkg::SRC_FOUR)
    else log_mismatch($sformatf("link operands wrong for inst %h", prev_inst));

  a_load: assert property (@(negedge i_clk)
    prev_valid && legal_with_opcode(prev_inst, idu_pkg::OP_LOAD) |->
    o_mem_re && o_mem_to_reg && !o_mem_wr && o_mem_op == exp_mem_op(prev_inst[14:12]))
    else log_mismatch($sformatf("load control wrong for inst %h", prev_inst));

  a_store: assert property (@(negedge i_clk)
    prev_valid && legal_with_opcode(prev_inst, idu_pkg::OP_STORE) |->
    o_mem_wr && !o_mem_re && o_mem_op == exp_mem_op(prev_inst[14:12]))
    else log_mismatch($sformatf("store control wrong for inst %h", prev_inst));

  a_branch: assert property (@(negedge i_clk) prev_valid
    && (is_jump(prev_inst) || legal_with_opcode(prev_inst, idu_pkg::OP_BRANCH)) |->
    o_bren && o_br_func == exp_br_func(prev_inst))
    else log_mismatch($sformatf("branch control wrong for inst %h", prev_inst));

  a_reg_wr: assert property (@(negedge i_clk) prev_valid |->
    o_reg_wr == exp_reg_wr(prev_inst))
    else log_mismatch($sformatf("reg_wr got %b for inst %h", o_reg_wr, prev_inst));

  a_invalid: assert property (@(negedge i_clk) prev_valid |->
    o_invalid == (!is_legal(prev_inst) && prev_inst != 32'd0))
    else log_mismatch($sformatf("invalid got %b for inst %h", o_invalid, prev_inst));

  a_rs1: assert property (@(negedge i_clk) prev_valid && rs1_known |-> o_rs1_data == exp_rs1)
    else log_mismatch($sformatf("rs1 data got %h exp %h", o_rs1_data, exp_rs1));

  a_rs2: assert property (@(negedge i_clk) prev_valid && rs2_known |-> o_rs2_data == exp_rs2)
    else log_mismatch($sformatf("rs2 data got %h exp %h", o_rs2_data, exp_rs2));

// File: verif/idu_tb.sv
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module idu_tb;

  logic                             i_clk = 1'b0;
  logic                             i_rst_n;
  logic                             i_inst_valid;
  logic [idu_pkg::INST_W-1:0]       i_inst;
  logic                             i_wb_wen;
  logic [idu_pkg::REG_ADDR_W-1:0]   i_wb_waddr;
  logic [idu_pkg::XLEN-1:0]         i_wb_wdata;

  logic                             o_dec_valid;
  logic [idu_pkg::REG_ADDR_W-1:0]   o_rd;
  idu_pkg::alu_op_e                 o_alu_op;
  logic                             o_alu_a_pc;
  idu_pkg::alu_b_src_e              o_alu_b_src;
  logic                             o_word_cut;
  logic                             o_reg_wr;
  logic                             o_mem_re;
  logic                             o_mem_wr;
  logic                             o_mem_to_reg;
  idu_pkg::mem_op_e                 o_mem_op;
  logic                             o_bren;
  idu_pkg::br_func_e                o_br_func;
  logic                             o_invalid;
  logic [idu_pkg::XLEN-1:0]         o_imm;
  logic [idu_pkg::XLEN-1:0]         o_rs1_data;
  logic [idu_pkg::XLEN-1:0]         o_rs2_data;

  int seed          = 32'haa07;
  int error_count   = 0;
  int timeout_count = 0;

  // inputs seen at the last rising edge
  logic                             prev_valid = 1'b0;
  logic                             prev_idle  = 1'b0;
  logic                             prev_rst   = 1'b0;
  logic [idu_pkg::INST_W-1:0]       prev_inst  = '0;

  logic [idu_pkg::XLEN-1:0]         gpr_model [idu_pkg::NUM_REGS];
  logic [idu_pkg::NUM_REGS-1:0]     gpr_known = '0;
  logic [idu_pkg::XLEN-1:0]         exp_rs1 = '0;
  logic [idu_pkg::XLEN-1:0]         exp_rs2 = '0;
  logic                             rs1_known = 1'b0;
  logic                             rs2_known = 1'b0;

  always #2 i_clk = ~i_clk;

  idu_top idu_top_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_wb_wen     (i_wb_wen),
    .i_wb_waddr   (i_wb_waddr),
    .i_wb_wdata   (i_wb_wdata),
    .o_dec_valid  (o_dec_valid),
    .o_rd         (o_rd),
    .o_alu_op     (o_alu_op),
    .o_alu_a_pc   (o_alu_a_pc),
    .o_alu_b_src  (o_alu_b_src),
    .o_word_cut   (o_word_cut),
    .o_reg_wr     (o_reg_wr),
    .o_mem_re     (o_mem_re),
    .o_mem_wr     (o_mem_wr),
    .o_mem_to_reg (o_mem_to_reg),
    .o_mem_op     (o_mem_op),
    .o_bren       (o_bren),
    .o_br_func    (o_br_func),
    .o_invalid    (o_invalid),
    .o_imm        (o_imm),
    .o_rs1_data   (o_rs1_data),
    .o_rs2_data   (o_rs2_data)
  );

  always @(posedge i_clk) begin
    prev_rst   <= !i_rst_n;
    prev_valid <= i_rst_n && i_inst_valid;
    prev_idle  <= !i_rst_n || !i_inst_valid;
    prev_inst  <= i_inst;
    exp_rs1    <= (i_inst[19:15] == 5'd0) ? '0 : gpr_model[i_inst[19:15]]; // old contents
    exp_rs2    <= (i_inst[24:20] == 5'd0) ? '0 : gpr_model[i_inst[24:20]];
    rs1_known  <= (i_inst[19:15] == 5'd0) || gpr_known[i_inst[19:15]];
    rs2_known  <= (i_inst[24:20] == 5'd0) || gpr_known[i_inst[24:20]];
    if (i_wb_wen && (i_wb_waddr != 5'd0)) begin
      gpr_model[i_wb_waddr] <= i_wb_wdata;
      gpr_known[i_wb_waddr] <= 1'b1;
    end
  end

  task automatic log_mismatch(input string msg);
    error_count++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic step(input logic valid, input logic [31:0] inst, input logic wen,
                      input logic [4:0] waddr, input logic [63:0] wdata);
    @(posedge i_clk);
    #1;
    i_inst_valid = valid;
    i_inst       = inst;
    i_wb_wen     = wen;
    i_wb_waddr   = waddr;
    i_wb_wdata   = wdata;
  endtask

  task automatic issue(input logic valid, input logic [31:0] inst);
    step(valid, inst, 1'b0, 5'd0, 64'd0);
  endtask

  task automatic wait_for_decode(input string what);
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while (!o_dec_valid && cycles < 8) begin
      @(negedge i_clk);
      cycles++;
    end
    if (!o_dec_valid) begin
      timeout_count++;
      $display("timeout: no decode output after the %s", what);
    end
  endtask

  `include "idu_tb_checks.svh"

  initial begin
    int          n;
    int          k;
    int          a;
    logic [31:0] r;
    logic [31:0] r2;
    logic [2:0]  f3;
    i_rst_n      = 1'b0;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    i_wb_wen     = 1'b0;
    i_wb_waddr   = '0;
    i_wb_wdata   = '0;
    repeat (16) @(posedge i_clk);
    #1 i_rst_n = 1'b1;
    issue(1'b0, 32'd0);

    for (n = 0; n < 16; n++) begin // immediates, all formats
      r = $random(seed);
      k = n % 6;
      f3 = (k < 2) ? k[2:0] : k[2:0] + 3'd2; // legal branch funct3
      issue(1'b1, {r[31:15], 3'b000, r[11:7], idu_pkg::OP_IMM});
      issue(1'b1, {r[31:15], 1'b0, r[13:12], r[11:7], idu_pkg::OP_STORE});
      issue(1'b1, {r[31:15], f3, r[11:7], idu_pkg::OP_BRANCH});
      issue(1'b1, {r[31:7], idu_pkg::OP_LUI});
      issue(1'b1, {r[31:7], idu_pkg::OP_AUIPC});
      issue(1'b1, {r[31:7], idu_pkg::OP_JAL});
      issue(1'b1, {r[31:15], 3'b000, r[11:7], idu_pkg::OP_JALR});
      if (n % 4 == 3) issue(1'b0, r); // garbage on an idle cycle
    end
    wait_for_decode("immediate tests");

    for (k = 0; k < 8; k++) begin
      for (a = 0; a < 2; a++) begin
        r = $random(seed);
        issue(1'b1, {1'b0, a[0], 5'b0, r[24:15], k[2:0], r[11:7], idu_pkg::OP_REG});
        issue(1'b1, {1'b0, a[0], 5'b0, r[24:15], k[2:0], r[11:7], idu_pkg::OP_REG_W});
        issue(1'b1, {1'b0, a[0], 4'b0, r[25:15], k[2:0], r[11:7], idu_pkg::OP_IMM});
        issue(1'b1, {1'b0, a[0], 5'b0, r[24:15], k[2:0], r[11:7], idu_pkg::OP_IMM_W});
        issue(1'b0, r);
      end
    end
    wait_for_decode("alu tests");

    for (k = 0; k < 8; k++) begin // every funct3, illegal ones too
      r = $random(seed);
      issue(1'b1, {r[31:15], k[2:0], r[11:7], idu_pkg::OP_LOAD});
      issue(1'b1, {r[31:15], k[2:0], r[11:7], idu_pkg::OP_STORE});
      issue(1'b1, {r[31:15], k[2:0], r[11:7], idu_pkg::OP_BRANCH});
      issue(1'b1, {r[31:15], k[2:0], r[11:7], idu_pkg::OP_JALR});
    end
    wait_for_decode("memory and branch tests");

    for (k = 1; k < 32; k++) begin
      r  = $random(seed);
      r2 = $random(seed);
      step(1'b0, 32'd0, 1'b1, k[4:0], {r, r2});
    end
    for (k = 0; k < 32; k++) begin
      a = 31 - k;
      issue(1'b1, {7'b0, a[4:0], k[4:0], 3'b000, 5'd1, idu_pkg::OP_REG});
    end
    step(1'b0, 32'd0, 1'b1, 5'd0, 64'hffff_ffff_ffff_ffff); // x0 must stay zero
    issue(1'b1, {7'b0, 5'd0, 5'd0, 3'b000, 5'd1, idu_pkg::OP_REG});
    r  = $random(seed);
    r2 = $random(seed);
    step(1'b1, {7'b0, 5'd6, 5'd5, 3'b000, 5'd1, idu_pkg::OP_REG}, 1'b1, 5'd5, {r2, r});
    issue(1'b1, {7'b0, 5'd6, 5'd5, 3'b000, 5'd1, idu_pkg::OP_REG});
    wait_for_decode("register file tests");

    for (k = 0; k < 8; k++) begin // mul/div family
      r = $random(seed);
      issue(1'b1, {7'b0000001, r[24:15], k[2:0], r[11:7], idu_pkg::OP_REG});
      issue(1'b1, {7'b0000001, r[24:15], k[2:0], r[11:7], idu_pkg::OP_REG_W});
    end
    r = $random(seed);
    issue(1'b1, 32'h0000_0073); // ecall
    issue(1'b1, 32'h0010_0073); // ebreak
    issue(1'b1, 32'h3020_0073); // mret
    issue(1'b1, {r[31:15], 3'b001, r[11:7], 7'b1110011});
    issue(1'b1, {r[31:7], 7'b0001111});
    issue(1'b1, {r[31:7], 7'b0101111});
    issue(1'b1, {r[31:7], 7'b1111111});
    issue(1'b1, 32'd0);
    wait_for_decode("invalid instruction tests");

    issue(1'b0, 32'd0);
    repeat (2) @(negedge i_clk);
    #1;
    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
